// ==== rc5ApbRegs.sv ====
module rc5ApbRegs
    import rc5Pkg::*;
(
    input  logic                     clk,
    input  logic                     clr,
    input  logic                     i_psel,
    input  logic                     i_penable,
    input  logic                     i_pwrite,
    input  logic [7:0]               i_paddr,
    input  logic [31:0]              i_pwdata,
    output logic [31:0]              o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    output logic                     o_keyStart,
    output rc5Word_t [rc5LWords-1:0] o_key,
    input  logic                     i_keyBusy,
    input  logic                     i_keyValid,
    output rc5Item_t                 o_item,
    output logic                     o_issue,
    input  rc5Block_u                i_head,
    input  logic [4:0]               i_count,
    input  logic                     i_canIssue,
    output logic                     o_pop
);

    rc5Block_u  dataReg;
    rc5Status_t status;
    logic [3:0] drainTimer;
    logic       access;
    logic       mapped;
    logic       isCtrlWr;
    logic       isResultRd;
    logic       loadReq;
    logic       encReq;
    logic       decReq;
    logic       keyAllowed;
    logic       cryptAllowed;
    logic       ctrlErr;
    logic       resultErr;

    assign access   = i_psel && i_penable;
    assign o_pready = 1'b1;

    ////////////////////
    // Control decode
    ////////////////////
    assign isCtrlWr   = access && i_pwrite && (i_paddr == regCtrl);
    assign isResultRd = access && !i_pwrite
                        && ((i_paddr == regResultHi) || (i_paddr == regResultLo));

    // Exactly one defined action bit
    assign loadReq = isCtrlWr && (i_pwdata == (32'd1 << ctrlLoadKey));
    assign encReq  = isCtrlWr && (i_pwdata == (32'd1 << ctrlEncrypt));
    assign decReq  = isCtrlWr && (i_pwdata == (32'd1 << ctrlDecrypt));

    // Key table must not change under a block in flight or queued
    assign keyAllowed   = !i_keyBusy && (drainTimer == 4'd0) && (i_count == 5'd0);
    assign cryptAllowed = !i_keyBusy && i_keyValid && i_canIssue;

    assign o_keyStart = loadReq && keyAllowed;
    assign o_issue    = (encReq || decReq) && cryptAllowed;
    assign o_item     = '{valid: o_issue, decrypt: decReq, block: dataReg};
    assign o_pop      = access && !i_pwrite && (i_paddr == regResultLo) && (i_count != 5'd0);

    assign ctrlErr   = isCtrlWr && !(o_keyStart || o_issue);
    assign resultErr = isResultRd && (i_count == 5'd0);
    assign o_pslverr = (access && !mapped) || ctrlErr || resultErr;

    assign status = '{reserved: '0, resultCount: i_count,
                      keyValid: i_keyValid, keyBusy: i_keyBusy};

    // Read mux, also flags unmapped offsets
    always_comb begin
        o_prdata = '0;
        mapped   = 1'b1;
        case (i_paddr)
            regKey0, regKey1, regKey2, regKey3: o_prdata = o_key[i_paddr[3:2]];
            regDataHi:   o_prdata = dataReg.raw[63:32];
            regDataLo:   o_prdata = dataReg.raw[31:0];
            regCtrl:     o_prdata = '0;
            regStatus:   o_prdata = status;
            regResultHi: o_prdata = (i_count != 5'd0) ? i_head.raw[63:32] : '0;
            regResultLo: o_prdata = (i_count != 5'd0) ? i_head.raw[31:0] : '0;
            default:     mapped = 1'b0;
        endcase
    end

    ////////////////////
    // Register writes
    ////////////////////
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_key   <= '0;
            dataReg <= '0;
        end else if (access && i_pwrite) begin
            case (i_paddr)
                regKey0, regKey1, regKey2, regKey3: o_key[i_paddr[3:2]] <= i_pwdata;
                regDataHi: dataReg.raw[63:32] <= i_pwdata;
                regDataLo: dataReg.raw[31:0]  <= i_pwdata;
                default: ;
            endcase
        end
    end

    // Counts down until the last issued block has reached the queue
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            drainTimer <= '0;
        end else if (o_issue) begin
            drainTimer <= 4'(rc5Latency);
        end else if (drainTimer != 4'd0) begin
            drainTimer <= drainTimer - 4'd1;
        end
    end

endmodule

// ==== rc5KeyExpand.sv ====
module rc5KeyExpand
    import rc5Pkg::*;
(
    input  logic                     clk,
    input  logic                     clr,
    input  logic                     i_start,
    input  rc5Word_t [rc5LWords-1:0] i_key,
    output logic                     o_busy,
    output logic                     o_valid,
    output rc5KeyTable_t             o_table
);

    rc5KeyTable_t             sTable;
    rc5Word_t [rc5LWords-1:0] lWords;
    rc5Word_t                 mixA;
    rc5Word_t                 mixB;
    rc5Word_t                 nextA;
    rc5Word_t                 nextB;
    rc5Word_t                 sumB;
    logic [4:0]               idxI;
    logic [1:0]               idxJ;
    logic [6:0]               stepCount;
    logic                     mixActive;

    // Busy covers the init cycle plus every mixing step
    assign mixActive = o_busy && (stepCount != 7'(rc5MixSteps));

    ////////////////////
    // One mixing step
    ////////////////////
    always_comb begin
        nextA = rotl(sTable[idxI] + mixA + mixB, 5'd3);
        sumB  = nextA + mixB;
        nextB = rotl(lWords[idxJ] + sumB, sumB[4:0]);
    end

    // Sequencing
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            o_busy    <= 1'b0;
            o_valid   <= 1'b0;
            stepCount <= '0;
            idxI      <= '0;
            idxJ      <= '0;
        end else if (i_start) begin
            o_busy    <= 1'b1;
            o_valid   <= 1'b0;
            stepCount <= '0;
            idxI      <= '0;
            idxJ      <= '0;
        end else if (mixActive) begin
            stepCount <= stepCount + 7'd1;
            idxI      <= (idxI == 5'(rc5KeyWords - 1)) ? 5'd0 : idxI + 5'd1;
            idxJ      <= (idxJ == 2'(rc5LWords - 1)) ? 2'd0 : idxJ + 2'd1;
        end else if (o_busy) begin
            // All 78 steps done
            o_busy  <= 1'b0;
            o_valid <= 1'b1;
        end
    end

    // S and L arrays
    always_ff @(posedge clk) begin
        if (i_start) begin
            for (int k = 0; k < rc5KeyWords; k++) begin
                sTable[k] <= rc5Pw + rc5Qw * rc5Word_t'(k);
            end
            lWords <= i_key;
            mixA   <= '0;
            mixB   <= '0;
        end else if (mixActive) begin
            sTable[idxI] <= nextA;
            lWords[idxJ] <= nextB;
            mixA         <= nextA;
            mixB         <= nextB;
        end
    end

    assign o_table = sTable;

endmodule

// ==== rc5Pipeline.sv ====
module rc5Pipeline
    import rc5Pkg::*;
(
    input  logic         clk,
    input  logic         clr,
    input  rc5Item_t     i_item,
    input  rc5KeyTable_t i_table,
    output rc5Item_t     o_item
);

    rc5Item_t  stageItem [rc5Rounds+1];
    rc5Block_u preBlock;
    rc5Block_u preQ;
    logic      preValid;
    logic      preDecrypt;
    rc5Block_u postBlock;
    rc5Block_u postQ;
    logic      postValid;
    logic      postDecrypt;

    ////////////////////
    // Pre-whitening
    ////////////////////
    always_comb begin
        preBlock = i_item.block;
        if (!i_item.decrypt) begin
            preBlock.halves.a = i_item.block.halves.a + i_table[0];
            preBlock.halves.b = i_item.block.halves.b + i_table[1];
        end
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            preValid  <= 1'b0;
            postValid <= 1'b0;
        end else begin
            preValid  <= i_item.valid;
            postValid <= stageItem[rc5Rounds].valid;
        end
    end

    always_ff @(posedge clk) begin
        preQ        <= preBlock;
        preDecrypt  <= i_item.decrypt;
        postQ       <= postBlock;
        postDecrypt <= stageItem[rc5Rounds].decrypt;
    end

    assign stageItem[0] = '{valid: preValid, decrypt: preDecrypt, block: preQ};

    // Twelve rounds, one register each
    for (genvar g = 0; g < rc5Rounds; g++) begin : genRound
        rc5RoundStage #(.stageIndex(g)) uRound (
            .clk     (clk),
            .clr     (clr),
            .i_item  (stageItem[g]),
            .i_table (i_table),
            .o_item  (stageItem[g+1])
        );
    end

    ////////////////////
    // Post-whitening
    ////////////////////
    always_comb begin
        postBlock = stageItem[rc5Rounds].block;
        if (stageItem[rc5Rounds].decrypt) begin
            postBlock.halves.a = stageItem[rc5Rounds].block.halves.a - i_table[0];
            postBlock.halves.b = stageItem[rc5Rounds].block.halves.b - i_table[1];
        end
    end

    assign o_item = '{valid: postValid, decrypt: postDecrypt, block: postQ};

endmodule

// ==== rc5Pkg.sv ====
package rc5Pkg;

    ////////////////////
    // Cipher constants
    ////////////////////
    localparam int rc5Rounds     = 12;
    localparam int rc5KeyWords   = 26;
    localparam int rc5LWords     = 4;
    localparam int rc5MixSteps   = 78;
    localparam int rc5QueueDepth = 16;
    // Pre-whitening, rounds and post-whitening
    localparam int rc5Latency    = rc5Rounds + 2;

    localparam logic [31:0] rc5Pw = 32'hB7E15163;
    localparam logic [31:0] rc5Qw = 32'h9E3779B9;

    ////////////////////
    // APB register map
    ////////////////////
    localparam logic [7:0] regKey0     = 8'h00;
    localparam logic [7:0] regKey1     = 8'h04;
    localparam logic [7:0] regKey2     = 8'h08;
    localparam logic [7:0] regKey3     = 8'h0C;
    localparam logic [7:0] regDataHi   = 8'h10;
    localparam logic [7:0] regDataLo   = 8'h14;
    localparam logic [7:0] regCtrl     = 8'h18;
    localparam logic [7:0] regStatus   = 8'h1C;
    localparam logic [7:0] regResultHi = 8'h20;
    localparam logic [7:0] regResultLo = 8'h24;

    // CTRL bit positions
    localparam int ctrlLoadKey = 0;
    localparam int ctrlEncrypt = 1;
    localparam int ctrlDecrypt = 2;

    typedef logic [31:0] rc5Word_t;

    typedef struct packed {
        rc5Word_t a;
        rc5Word_t b;
    } rc5Halves_t;

    // Raw word on the register side, halves inside the rounds
    typedef union packed {
        logic [63:0] raw;
        rc5Halves_t  halves;
    } rc5Block_u;

    typedef rc5Word_t [rc5KeyWords-1:0] rc5KeyTable_t;

    typedef struct packed {
        logic      valid;
        logic      decrypt;
        rc5Block_u block;
    } rc5Item_t;

    typedef struct packed {
        logic [24:0] reserved;
        logic [4:0]  resultCount;
        logic        keyValid;
        logic        keyBusy;
    } rc5Status_t;

    // Rotates through a doubled word so a zero amount needs no special case
    function automatic rc5Word_t rotl(rc5Word_t x, logic [4:0] n);
        logic [63:0] d;
        d = {x, x} << n;
        return d[63:32];
    endfunction

    function automatic rc5Word_t rotr(rc5Word_t x, logic [4:0] n);
        logic [63:0] d;
        d = {x, x} >> n;
        return d[31:0];
    endfunction

endpackage

// ==== rc5ResultQueue.sv ====
module rc5ResultQueue
    import rc5Pkg::*;
(
    input  logic       clk,
    input  logic       clr,
    input  logic       i_issue,
    input  rc5Item_t   i_push,
    input  logic       i_pop,
    output rc5Block_u  o_head,
    output logic [4:0] o_count,
    output logic       o_canIssue
);

    rc5Block_u  mem [rc5QueueDepth];
    logic [3:0] wrPtr;
    logic [3:0] rdPtr;
    logic [4:0] inFlight;
    logic [5:0] pending;
    logic       doPop;

    // Never pop an empty queue
    assign doPop = i_pop && (o_count != 5'd0);

    // Room must remain for every block still in the rounds
    assign pending    = {1'b0, inFlight} + {1'b0, o_count} + 6'd1;
    assign o_canIssue = pending < 6'(rc5QueueDepth);

    assign o_head = mem[rdPtr];

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clk) begin
        if (i_push.valid) begin
            mem[wrPtr] <= i_push.block;
        end
    end

    // Pointers and counters
    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            o_count  <= '0;
            inFlight <= '0;
        end else begin
            if (i_push.valid) begin
                wrPtr <= wrPtr + 4'd1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 4'd1;
            end
            o_count  <= o_count + 5'(i_push.valid) - 5'(doPop);
            inFlight <= inFlight + 5'(i_issue) - 5'(i_push.valid);
        end
    end

endmodule

// ==== rc5RoundStage.sv ====
module rc5RoundStage
    import rc5Pkg::*;
#(
    parameter int stageIndex = 0
) (
    input  logic         clk,
    input  logic         clr,
    input  rc5Item_t     i_item,
    input  rc5KeyTable_t i_table,
    output rc5Item_t     o_item
);

    rc5Word_t  encA;
    rc5Word_t  encB;
    rc5Word_t  decA;
    rc5Word_t  decB;
    rc5Block_u nextBlock;
    rc5Block_u blockQ;
    logic      validQ;
    logic      decryptQ;

    ////////////////////
    // Round datapath
    ////////////////////
    always_comb begin
        // Encrypt round stageIndex+1
        encA = rotl(i_item.block.halves.a ^ i_item.block.halves.b,
                    i_item.block.halves.b[4:0]) + i_table[2*stageIndex+2];
        encB = rotl(i_item.block.halves.b ^ encA, encA[4:0]) + i_table[2*stageIndex+3];

        // Decrypt walks the rounds backwards, 12 down to 1
        decB = rotr(i_item.block.halves.b - i_table[2*(rc5Rounds-stageIndex)+1],
                    i_item.block.halves.a[4:0]) ^ i_item.block.halves.a;
        decA = rotr(i_item.block.halves.a - i_table[2*(rc5Rounds-stageIndex)],
                    decB[4:0]) ^ decB;

        if (i_item.decrypt) begin
            nextBlock.halves.a = decA;
            nextBlock.halves.b = decB;
        end else begin
            nextBlock.halves.a = encA;
            nextBlock.halves.b = encB;
        end
    end

    always_ff @(posedge clk or posedge clr) begin
        if (clr) begin
            validQ <= 1'b0;
        end else begin
            validQ <= i_item.valid;
        end
    end

    always_ff @(posedge clk) begin
        decryptQ <= i_item.decrypt;
        blockQ   <= nextBlock;
    end

    assign o_item = '{valid: validQ, decrypt: decryptQ, block: blockQ};

endmodule

// ==== rc5Top.f ====
+incdir+.
rc5Pkg.sv
rc5KeyExpand.sv
rc5RoundStage.sv
rc5Pipeline.sv
rc5ResultQueue.sv
rc5ApbRegs.sv
rc5Top.sv
tbRc5Top.sv

// ==== rc5Top.sv ====
module rc5Top
    import rc5Pkg::*;
(
    input  logic        clk,
    input  logic        clr,
    input  logic        i_psel,
    input  logic        i_penable,
    input  logic        i_pwrite,
    input  logic [7:0]  i_paddr,
    input  logic [31:0] i_pwdata,
    output logic [31:0] o_prdata,
    output logic        o_pready,
    output logic        o_pslverr
);

    logic                     keyStart;
    rc5Word_t [rc5LWords-1:0] keyWords;
    logic                     keyBusy;
    logic                     keyValid;
    rc5KeyTable_t             keyTable;
    rc5Item_t                 issueItem;
    rc5Item_t                 doneItem;
    logic                     issue;
    rc5Block_u                head;
    logic [4:0]               count;
    logic                     canIssue;
    logic                     pop;

    rc5ApbRegs uRegs (
        .clk(clk), .clr(clr),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_keyStart(keyStart), .o_key(keyWords),
        .i_keyBusy(keyBusy), .i_keyValid(keyValid),
        .o_item(issueItem), .o_issue(issue),
        .i_head(head), .i_count(count), .i_canIssue(canIssue), .o_pop(pop)
    );

    rc5KeyExpand uKey (
        .clk(clk), .clr(clr), .i_start(keyStart), .i_key(keyWords),
        .o_busy(keyBusy), .o_valid(keyValid), .o_table(keyTable)
    );

    rc5Pipeline uPipe (
        .clk(clk), .clr(clr), .i_item(issueItem), .i_table(keyTable), .o_item(doneItem)
    );

    rc5ResultQueue uQueue (
        .clk(clk), .clr(clr), .i_issue(issue), .i_push(doneItem), .i_pop(pop),
        .o_head(head), .o_count(count), .o_canIssue(canIssue)
    );

endmodule

// ==== tbRc5Model.svh ====
`ifndef TBRC5MODEL_SVH
`define TBRC5MODEL_SVH

// Reference RC5-32/12, A is the upper half and B the lower half
logic [31:0] modelKey [4];
logic [31:0] modelS [26];
logic [31:0] lcgState;

function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

function automatic logic [31:0] modelRotl(logic [31:0] x, logic [31:0] n);
    int s;
    s = n % 32;
    if (s == 0) begin
        return x;
    end
    return (x << s) | (x >> (32 - s));
endfunction

function automatic logic [31:0] modelRotr(logic [31:0] x, logic [31:0] n);
    int s;
    s = n % 32;
    if (s == 0) begin
        return x;
    end
    return (x >> s) | (x << (32 - s));
endfunction

////////////////////
// Key schedule
////////////////////
function automatic void modelExpandKey();
    logic [31:0] l [4];
    logic [31:0] a;
    logic [31:0] b;
    int          i;
    int          j;
    modelS[0] = 32'hB7E15163;
    for (int k = 1; k < 26; k++) begin
        modelS[k] = modelS[k-1] + 32'h9E3779B9;
    end
    for (int k = 0; k < 4; k++) begin
        l[k] = modelKey[k];
    end
    a = '0;
    b = '0;
    i = 0;
    j = 0;
    // 3 * max(26, 4) mixing steps
    for (int step = 0; step < 78; step++) begin
        a = modelRotl(modelS[i] + a + b, 3);
        modelS[i] = a;
        b = modelRotl(l[j] + a + b, a + b);
        l[j] = b;
        i = (i + 1) % 26;
        j = (j + 1) % 4;
    end
endfunction

function automatic logic [63:0] encryptBlock(logic [63:0] pt);
    logic [31:0] a;
    logic [31:0] b;
    a = pt[63:32] + modelS[0];
    b = pt[31:0] + modelS[1];
    for (int r = 1; r <= 12; r++) begin
        a = modelRotl(a ^ b, b) + modelS[2*r];
        b = modelRotl(b ^ a, a) + modelS[2*r+1];
    end
    return {a, b};
endfunction

function automatic logic [63:0] decryptBlock(logic [63:0] ct);
    logic [31:0] a;
    logic [31:0] b;
    a = ct[63:32];
    b = ct[31:0];
    for (int r = 12; r >= 1; r--) begin
        b = modelRotr(b - modelS[2*r+1], a) ^ a;
        a = modelRotr(a - modelS[2*r], b) ^ b;
    end
    return {a - modelS[0], b - modelS[1]};
endfunction

`endif

// ==== tbRc5Top.sv ====
module tbRc5Top
    import rc5Pkg::*;
();

    logic        clk;
    logic        clr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          checkCount;
    int          errorCount;

    `include "tbRc5Model.svh"

    rc5Top dut (
        .clk(clk), .clr(clr),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
    );

    always #2 clk = ~clk;

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic checkBlock(input string name, input rc5Block_u got, input rc5Block_u exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error %s got 0x%016h expected 0x%016h", name, got.raw, exp.raw);
        end
    endtask

    task automatic checkStatus(input string name, input rc5Status_t got, input rc5Status_t exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic checkErr(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic rc5Status_t statusImage(logic busy, logic valid, logic [4:0] count);
        rc5Status_t st;
        st = '0;
        st.keyBusy = busy;
        st.keyValid = valid;
        st.resultCount = count;
        return st;
    endfunction

    function automatic logic [63:0] randomBlock();
        logic [63:0] blk;
        blk[63:32] = nextRandom();
        blk[31:0] = nextRandom();
        return blk;
    endfunction

    ////////////////////
    // APB access
    ////////////////////
    // Called one unit after a rising edge; returns at the same point
    task automatic apbTransfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        int waitCycles;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waitCycles = 0;
        @(negedge clk);
        while (!pready && waitCycles < 16) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!pready) begin
            errorCount++;
            $display("APB transfer to offset 0x%02h never completed", addr);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
        apbTransfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic readStatus(output rc5Status_t st);
        logic [31:0] data;
        logic        err;
        apbRead(regStatus, data, err);
        checkErr("pslverr status", err, 1'b0);
        st = data;
    endtask

    task automatic waitForStatus(input logic wantValid, input logic [4:0] wantCount);
        rc5Status_t st;
        logic       reached;
        int         cycles;
        cycles = 0;
        readStatus(st);
        reached = !st.keyBusy && st.keyValid == wantValid && st.resultCount == wantCount;
        while (!reached && cycles < 200) begin
            readStatus(st);
            cycles += 2;
            reached = !st.keyBusy && st.keyValid == wantValid && st.resultCount == wantCount;
        end
        if (!reached) begin
            errorCount++;
            $display("STATUS did not reach key valid %0d and count %0d within 200 cycles",
                     wantValid, wantCount);
        end
    endtask

    task automatic writeRandomKey();
        logic err;
        for (int k = 0; k < 4; k++) begin
            modelKey[k] = nextRandom();
            apbWrite(regKey0 + 8'(4 * k), modelKey[k], err);
            checkErr("pslverr key", err, 1'b0);
        end
    endtask

    task automatic issueBlock(input logic [63:0] blk, input int ctrlBit, output logic err);
        logic e;
        apbWrite(regDataHi, blk[63:32], e);
        checkErr("pslverr data hi", e, 1'b0);
        apbWrite(regDataLo, blk[31:0], e);
        checkErr("pslverr data lo", e, 1'b0);
        apbWrite(regCtrl, 32'd1 << ctrlBit, err);
    endtask

    task automatic popResult(output rc5Block_u blk);
        logic [31:0] hi;
        logic [31:0] lo;
        logic        e;
        apbRead(regResultHi, hi, e);
        checkErr("pslverr result hi", e, 1'b0);
        apbRead(regResultLo, lo, e);
        checkErr("pslverr result lo", e, 1'b0);
        blk.raw = {hi, lo};
    endtask

    task automatic reportTest(input string name, input int startErrors);
        if (errorCount == startErrors) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s %0d errors", name, errorCount - startErrors);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic resetDefaults();
        rc5Status_t  st;
        rc5Block_u   got;
        rc5Block_u   zero;
        logic [31:0] hi;
        logic [31:0] lo;
        logic        err;
        zero.raw = '0;
        readStatus(st);
        checkStatus("status", st, statusImage(1'b0, 1'b0, 5'd0));
        apbRead(regResultHi, hi, err);
        checkErr("pslverr result hi", err, 1'b1);
        apbRead(regResultLo, lo, err);
        checkErr("pslverr result lo", err, 1'b1);
        got.raw = {hi, lo};
        checkBlock("prdata result", got, zero);
    endtask

    task automatic encryptBurst();
        logic [63:0] plain [8];
        rc5Block_u   got;
        rc5Block_u   exp;
        logic        err;
        writeRandomKey();
        apbWrite(regCtrl, 32'd1 << ctrlLoadKey, err);
        checkErr("pslverr load key", err, 1'b0);
        modelExpandKey();
        waitForStatus(1'b1, 5'd0);
        for (int k = 0; k < 8; k++) begin
            plain[k] = randomBlock();
            issueBlock(plain[k], ctrlEncrypt, err);
            checkErr("pslverr encrypt", err, 1'b0);
        end
        waitForStatus(1'b1, 5'd8);
        for (int k = 0; k < 8; k++) begin
            popResult(got);
            exp.raw = encryptBlock(plain[k]);
            checkBlock("cipher result", got, exp);
        end
    endtask

    task automatic decryptBurst();
        logic [63:0] cipher [8];
        logic [63:0] orig;
        rc5Block_u   got;
        rc5Block_u   exp;
        logic        err;
        for (int k = 0; k < 8; k++) begin
            cipher[k] = randomBlock();
            issueBlock(cipher[k], ctrlDecrypt, err);
            checkErr("pslverr decrypt", err, 1'b0);
        end
        waitForStatus(1'b1, 5'd8);
        for (int k = 0; k < 8; k++) begin
            popResult(got);
            exp.raw = decryptBlock(cipher[k]);
            checkBlock("plain result", got, exp);
        end
        // Round trip through both directions
        orig = randomBlock();
        issueBlock(orig, ctrlEncrypt, err);
        checkErr("pslverr encrypt", err, 1'b0);
        waitForStatus(1'b1, 5'd1);
        popResult(got);
        exp.raw = encryptBlock(orig);
        checkBlock("round trip cipher", got, exp);
        issueBlock(got.raw, ctrlDecrypt, err);
        checkErr("pslverr decrypt", err, 1'b0);
        waitForStatus(1'b1, 5'd1);
        popResult(got);
        exp.raw = orig;
        checkBlock("round trip plain", got, exp);
    endtask

    task automatic queueFull();
        logic [63:0] plain [16];
        rc5Status_t  st;
        rc5Block_u   got;
        rc5Block_u   exp;
        logic        err;
        for (int k = 0; k < 16; k++) begin
            plain[k] = randomBlock();
            issueBlock(plain[k], ctrlEncrypt, err);
            checkErr("pslverr encrypt", err, k == 15);
        end
        waitForStatus(1'b1, 5'd15);
        readStatus(st);
        checkStatus("status", st, statusImage(1'b0, 1'b1, 5'd15));
        for (int k = 0; k < 15; k++) begin
            popResult(got);
            exp.raw = encryptBlock(plain[k]);
            checkBlock("cipher result", got, exp);
        end
    endtask

    task automatic refusedAccesses();
        logic [63:0] plain;
        logic [31:0] data;
        rc5Status_t  st;
        rc5Block_u   got;
        rc5Block_u   exp;
        logic        err;
        writeRandomKey();
        apbWrite(regCtrl, 32'd1 << ctrlLoadKey, err);
        checkErr("pslverr load key", err, 1'b0);
        modelExpandKey();
        issueBlock(randomBlock(), ctrlEncrypt, err);
        checkErr("pslverr encrypt while busy", err, 1'b1);
        readStatus(st);
        checkStatus("status", st, statusImage(1'b1, 1'b0, 5'd0));
        waitForStatus(1'b1, 5'd0);

        plain = randomBlock();
        issueBlock(plain, ctrlEncrypt, err);
        checkErr("pslverr encrypt", err, 1'b0);
        waitForStatus(1'b1, 5'd1);
        apbWrite(regCtrl, 32'd1 << ctrlLoadKey, err);
        checkErr("pslverr load while queued", err, 1'b1);
        readStatus(st);
        checkStatus("status", st, statusImage(1'b0, 1'b1, 5'd1));

        // Encrypt and decrypt together
        apbWrite(regCtrl, (32'd1 << ctrlEncrypt) | (32'd1 << ctrlDecrypt), err);
        checkErr("pslverr two ctrl bits", err, 1'b1);
        readStatus(st);
        checkStatus("status", st, statusImage(1'b0, 1'b1, 5'd1));

        apbWrite(8'h28, nextRandom(), err);
        checkErr("pslverr unmapped write", err, 1'b1);
        apbRead(8'h40, data, err);
        checkErr("pslverr unmapped read", err, 1'b1);
        // A stray start would reach the queue within the 14-cycle latency
        repeat (14) @(posedge clk);
        #1;
        readStatus(st);
        checkStatus("status", st, statusImage(1'b0, 1'b1, 5'd1));

        // Key table must be the one loaded above
        popResult(got);
        exp.raw = encryptBlock(plain);
        checkBlock("cipher result", got, exp);
    endtask

    initial begin
        int startErrors;
        clk = 1'b0;
        clr = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        checkCount = 0;
        errorCount = 0;
        lcgState = 32'hc825;
        repeat (2) @(posedge clk);
        #1;
        clr = 1'b0;

        startErrors = errorCount;
        resetDefaults();
        reportTest("reset defaults", startErrors);
        startErrors = errorCount;
        encryptBurst();
        reportTest("encrypt burst", startErrors);
        startErrors = errorCount;
        decryptBurst();
        reportTest("decrypt burst", startErrors);
        startErrors = errorCount;
        queueFull();
        reportTest("queue full", startErrors);
        startErrors = errorCount;
        refusedAccesses();
        reportTest("refused accesses", startErrors);

        $display("checks %0d errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
